/* common/cache_consts.svh */
/*
  SDRAM cache constants
  geometry of the direct-mapped cache, SDRAM read latency and refresh period
*/
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// 8 words of 4 bytes per line
`define CACHE_COL_BITS 3
`define CACHE_COLUMNS (1 << `CACHE_COL_BITS)
// 64 lines, 2 KB of cached data
`define CACHE_LINE_BITS 6
`define CACHE_LINES (1 << `CACHE_LINE_BITS)
// word address into the SDRAM controller
`define CACHE_RAM_ADDR_BITS 21
`define CACHE_TAG_BITS (`CACHE_RAM_ADDR_BITS - `CACHE_LINE_BITS - `CACHE_COL_BITS)
// cycles after the read strobe before word 0 shows up (CL=2)
`define CACHE_READ_WAITS 4
// idle cycles between auto-refresh commands
`define CACHE_REFRESH_PERIOD 600
// flags stored just above the tag
`define CACHE_VALID_BIT (`CACHE_TAG_BITS)
`define CACHE_DIRTY_BIT (`CACHE_TAG_BITS + 1)

`endif

/* common/cache_pkg.sv */
/*
  SDRAM cache package
  data, address field and controller command types plus sequencer states
*/
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0] byte_en_t;

  // fields of the byte address |tag|line|col|00|
  typedef logic [`CACHE_COL_BITS-1:0] col_ix_t;
  typedef logic [`CACHE_LINE_BITS-1:0] line_ix_t;
  typedef logic [`CACHE_TAG_BITS-1:0] tag_t;
  typedef logic [`CACHE_RAM_ADDR_BITS-1:0] ram_addr_t;

  // controller command opcodes
  typedef enum logic [2:0] {
    CMD_REFRESH  = 3'b001,
    CMD_ACTIVATE = 3'b011,
    CMD_WRITE    = 3'b100,
    CMD_READ     = 3'b101
  } sdrc_cmd_e;

  typedef enum logic [3:0] {
    S_INIT,
    S_IDLE,
    S_EVICT_ACT,
    S_EVICT_DATA,
    S_EVICT_ACK,
    S_FILL_ACT,
    S_FILL_WAIT,
    S_FILL_DATA,
    S_FILL_LAST,
    S_FILL_TAG
  } seq_state_e;

endpackage

`default_nettype wire

/* cache/line_ram.sv */
/*
  line RAM
  one word per cache line, byte-enabled write, registered read
  a written byte shows on the output in the next cycle
*/
`default_nettype none

`include "cache_consts.svh"

module line_ram (
  input  wire clk,
  input  wire cache_pkg::byte_en_t write_enable,
  input  wire cache_pkg::line_ix_t address,
  input  wire cache_pkg::word_t data_in,
  output cache_pkg::word_t data_out
);

  cache_pkg::word_t mem [`CACHE_LINES];

  // lines start out invalid
  initial begin
    for (int i = 0; i < `CACHE_LINES; i++) begin
      mem[i] = '0;
    end
  end

  // write-first per byte so a fresh tag is seen right after the write
  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (write_enable[b]) begin
        mem[address][b*8 +: 8] <= data_in[b*8 +: 8];
        data_out[b*8 +: 8] <= data_in[b*8 +: 8];
      end else begin
        data_out[b*8 +: 8] <= mem[address][b*8 +: 8];
      end
    end
  end

endmodule

`default_nettype wire

/* cache/line_fill_steer.sv */
/*
  line fill steering
  picks burst fill data or host write data for the column RAMs
  and builds the tag word with its valid and dirty flags
*/
`default_nettype none

`include "cache_consts.svh"

module line_fill_steer (
  input  wire fill_active,
  input  wire cache_pkg::byte_en_t fill_enable [`CACHE_COLUMNS],
  input  wire cache_pkg::word_t fill_data [`CACHE_COLUMNS],
  input  wire tag_commit,
  input  wire hit,
  input  wire cache_pkg::col_ix_t column_ix,
  input  wire cache_pkg::tag_t address_tag,
  input  wire cache_pkg::word_t data_in,
  input  wire cache_pkg::byte_en_t write_enable,
  output cache_pkg::byte_en_t column_enable [`CACHE_COLUMNS],
  output cache_pkg::word_t column_data [`CACHE_COLUMNS],
  output cache_pkg::byte_en_t tag_enable,
  output cache_pkg::word_t tag_data
);

  always_comb begin
    // host data on every column, nothing written by default
    for (int i = 0; i < `CACHE_COLUMNS; i++) begin
      column_enable[i] = '0;
      column_data[i] = data_in;
    end
    tag_enable = '0;
    // {dirty, valid, tag}, a freshly filled line is clean
    tag_data = '0;
    tag_data[`CACHE_TAG_BITS-1:0] = address_tag;
    tag_data[`CACHE_VALID_BIT] = 1'b1;
    tag_data[`CACHE_DIRTY_BIT] = !fill_active;

    if (fill_active) begin
      // burst registers own the line
      for (int i = 0; i < `CACHE_COLUMNS; i++) begin
        column_enable[i] = fill_enable[i];
        column_data[i] = fill_data[i];
      end
      tag_enable = {4{tag_commit}};
    end else if (hit && write_enable != '0) begin
      // write hit marks the line dirty
      column_enable[column_ix] = write_enable;
      tag_enable = '1;
    end
  end

endmodule

`default_nettype wire

/* cache/line_lookup.sv */
/*
  line lookup
  splits the stored tag word, compares it with the address tag
  and selects the column words for the host and for eviction
*/
`default_nettype none

`include "cache_consts.svh"

module line_lookup (
  input  wire cache_pkg::word_t tag_word,
  input  wire cache_pkg::word_t column_words [`CACHE_COLUMNS],
  input  wire cache_pkg::tag_t address_tag,
  input  wire cache_pkg::col_ix_t column_ix,
  input  wire cache_pkg::col_ix_t flush_ix,
  output logic hit,
  output logic dirty,
  output cache_pkg::tag_t victim_tag,
  output cache_pkg::word_t host_word,
  output cache_pkg::word_t flush_word
);

  cache_pkg::tag_t stored_tag;
  logic valid;

  assign stored_tag = tag_word[`CACHE_TAG_BITS-1:0];
  assign valid = tag_word[`CACHE_VALID_BIT];

  // a dirty flag only counts on a valid line
  assign hit = valid && stored_tag == address_tag;
  assign dirty = valid && tag_word[`CACHE_DIRTY_BIT];

  // line currently held, written back before the fill
  assign victim_tag = stored_tag;

  assign host_word = column_words[column_ix];
  assign flush_word = column_words[flush_ix];

endmodule

`default_nettype wire

/* cache/sdram_sequencer.sv */
/*
  SDRAM sequencer
  drives the controller command port: init refresh, periodic refresh,
  dirty line eviction burst and line fill burst
*/
`default_nettype none

`include "cache_consts.svh"

module sdram_sequencer (
  input  wire clk,
  input  wire rst_n,
  input  wire enable,
  input  wire hit,
  input  wire dirty,
  input  wire cache_pkg::line_ix_t line_ix,
  input  wire cache_pkg::tag_t address_tag,
  input  wire cache_pkg::tag_t victim_tag,
  input  wire cache_pkg::word_t flush_word,
  output cache_pkg::col_ix_t flush_ix,
  output logic fill_active,
  output cache_pkg::byte_en_t fill_enable [`CACHE_COLUMNS],
  output cache_pkg::word_t fill_data [`CACHE_COLUMNS],
  output logic tag_commit,
  input  wire sdrc_init_done,
  input  wire sdrc_cmd_ack,
  input  wire cache_pkg::word_t sdrc_data_out,
  output logic sdrc_cmd_en,
  output cache_pkg::sdrc_cmd_e sdrc_cmd,
  output cache_pkg::ram_addr_t sdrc_addr,
  output cache_pkg::word_t sdrc_data,
  output logic [7:0] sdrc_data_len
);

  cache_pkg::seq_state_e state;
  cache_pkg::col_ix_t col;
  cache_pkg::ram_addr_t fill_addr;
  cache_pkg::ram_addr_t victim_addr;
  logic [3:0] wait_count;
  logic [15:0] refresh_count;
  logic ack_seen;
  logic ack_ok;

  // ack may land mid-burst, so it is remembered until the next strobe
  assign ack_ok = ack_seen || sdrc_cmd_ack;

  // line start addresses, column bits zero
  assign fill_addr = {address_tag, line_ix, {`CACHE_COL_BITS{1'b0}}};
  assign victim_addr = {victim_tag, line_ix, {`CACHE_COL_BITS{1'b0}}};

  assign flush_ix = col;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= cache_pkg::S_INIT;
      sdrc_cmd_en <= 1'b0;
      ack_seen <= 1'b1;
      fill_active <= 1'b0;
      tag_commit <= 1'b0;
      col <= '0;
      wait_count <= '0;
      refresh_count <= '0;
      for (int i = 0; i < `CACHE_COLUMNS; i++) begin
        fill_enable[i] <= '0;
      end
    end else begin
      // strobe lasts one cycle
      sdrc_cmd_en <= 1'b0;
      if (sdrc_cmd_ack) begin
        ack_seen <= 1'b1;
      end

      unique case (state)
        cache_pkg::S_INIT: begin
          // first refresh once the controller is up
          if (sdrc_init_done) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= cache_pkg::CMD_REFRESH;
            ack_seen <= 1'b0;
            refresh_count <= '0;
            state <= cache_pkg::S_IDLE;
          end
        end

        cache_pkg::S_IDLE: begin
          refresh_count <= refresh_count + 1'b1;
          col <= '0;
          // nothing new goes out before the last command is acked
          if (ack_ok) begin
            if (refresh_count >= 16'(`CACHE_REFRESH_PERIOD)) begin
              sdrc_cmd_en <= 1'b1;
              sdrc_cmd <= cache_pkg::CMD_REFRESH;
              ack_seen <= 1'b0;
              refresh_count <= '0;
            end else if (enable && !hit) begin
              // miss, open the row of the victim or of the new line
              sdrc_cmd_en <= 1'b1;
              sdrc_cmd <= cache_pkg::CMD_ACTIVATE;
              ack_seen <= 1'b0;
              if (dirty) begin
                sdrc_addr <= victim_addr;
                state <= cache_pkg::S_EVICT_ACT;
              end else begin
                sdrc_addr <= fill_addr;
                fill_active <= 1'b1;
                state <= cache_pkg::S_FILL_ACT;
              end
            end
          end
        end

        cache_pkg::S_EVICT_ACT: begin
          // write strobe carries word 0
          if (ack_ok) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= cache_pkg::CMD_WRITE;
            sdrc_addr <= victim_addr;
            sdrc_data_len <= 8'(`CACHE_COLUMNS - 1);
            sdrc_data <= flush_word;
            ack_seen <= 1'b0;
            col <= col + 1'b1;
            state <= cache_pkg::S_EVICT_DATA;
          end
        end

        cache_pkg::S_EVICT_DATA: begin
          // words 1 to 7 back to back
          sdrc_data <= flush_word;
          col <= col + 1'b1;
          if (col == '1) begin
            state <= cache_pkg::S_EVICT_ACK;
          end
        end

        cache_pkg::S_EVICT_ACK: begin
          if (ack_ok) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= cache_pkg::CMD_ACTIVATE;
            sdrc_addr <= fill_addr;
            ack_seen <= 1'b0;
            fill_active <= 1'b1;
            state <= cache_pkg::S_FILL_ACT;
          end
        end

        cache_pkg::S_FILL_ACT: begin
          if (ack_ok) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= cache_pkg::CMD_READ;
            sdrc_addr <= fill_addr;
            sdrc_data_len <= 8'(`CACHE_COLUMNS - 1);
            ack_seen <= 1'b0;
            wait_count <= '0;
            state <= cache_pkg::S_FILL_WAIT;
          end
        end

        cache_pkg::S_FILL_WAIT: begin
          // count from the strobe cycle up to the first data word
          wait_count <= wait_count + 1'b1;
          if (wait_count == 4'(`CACHE_READ_WAITS)) begin
            col <= '0;
            state <= cache_pkg::S_FILL_DATA;
          end
        end

        cache_pkg::S_FILL_DATA: begin
          // capture word, the column RAM takes it next cycle
          for (int i = 0; i < `CACHE_COLUMNS; i++) begin
            fill_enable[i] <= (col == cache_pkg::col_ix_t'(i)) ? 4'b1111 : 4'b0000;
          end
          fill_data[col] <= sdrc_data_out;
          col <= col + 1'b1;
          if (col == '1) begin
            state <= cache_pkg::S_FILL_LAST;
          end
        end

        cache_pkg::S_FILL_LAST: begin
          // last column being written now, tag follows
          for (int i = 0; i < `CACHE_COLUMNS; i++) begin
            fill_enable[i] <= '0;
          end
          tag_commit <= 1'b1;
          state <= cache_pkg::S_FILL_TAG;
        end

        cache_pkg::S_FILL_TAG: begin
          tag_commit <= 1'b0;
          fill_active <= 1'b0;
          state <= cache_pkg::S_IDLE;
        end

        default: state <= cache_pkg::S_INIT;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/sdram_cache.sv */
/*
  SDRAM cache top
  direct-mapped write-back cache between a 32-bit host port
  and an SDRAM controller command port
*/
`default_nettype none

`include "cache_consts.svh"

module sdram_cache (
  input  wire clk,
  input  wire rst_n,
  input  wire enable,
  input  wire [31:0] address,
  input  wire cache_pkg::word_t data_in,
  input  wire cache_pkg::byte_en_t write_enable,
  output cache_pkg::word_t data_out,
  output logic data_out_ready,
  output logic busy,
  output logic sdrc_cmd_en,
  output cache_pkg::sdrc_cmd_e sdrc_cmd,
  output cache_pkg::ram_addr_t sdrc_addr,
  output cache_pkg::word_t sdrc_data,
  output logic [7:0] sdrc_data_len,
  input  wire cache_pkg::word_t sdrc_data_out,
  input  wire sdrc_init_done,
  input  wire sdrc_cmd_ack
);

  cache_pkg::col_ix_t column_ix;
  cache_pkg::line_ix_t line_ix;
  cache_pkg::tag_t address_tag;
  cache_pkg::tag_t victim_tag;
  cache_pkg::col_ix_t flush_ix;
  cache_pkg::word_t flush_word;
  cache_pkg::word_t tag_word;
  cache_pkg::word_t tag_data;
  cache_pkg::byte_en_t tag_enable;
  cache_pkg::byte_en_t fill_enable [`CACHE_COLUMNS];
  cache_pkg::word_t fill_data [`CACHE_COLUMNS];
  cache_pkg::byte_en_t column_enable [`CACHE_COLUMNS];
  cache_pkg::word_t column_data [`CACHE_COLUMNS];
  cache_pkg::word_t column_words [`CACHE_COLUMNS];
  logic hit;
  logic dirty;
  logic fill_active;
  logic tag_commit;

  // |tag|line|col|00| with the two low bits ignored
  assign column_ix = address[`CACHE_COL_BITS+1:2];
  assign line_ix = address[`CACHE_LINE_BITS+`CACHE_COL_BITS+1:`CACHE_COL_BITS+2];
  assign address_tag = address[`CACHE_RAM_ADDR_BITS+1:`CACHE_LINE_BITS+`CACHE_COL_BITS+2];

  assign busy = enable && !hit;
  // writes never report data
  assign data_out_ready = enable && hit && write_enable == '0;

  // tag, valid and dirty per line
  line_ram tag_ram (
    .clk, .write_enable(tag_enable), .address(line_ix),
    .data_in(tag_data), .data_out(tag_word)
  );

  for (genvar i = 0; i < `CACHE_COLUMNS; i++) begin : g_column
    line_ram column_ram (
      .clk, .write_enable(column_enable[i]), .address(line_ix),
      .data_in(column_data[i]), .data_out(column_words[i])
    );
  end

  // host writes land only while a request is up
  line_fill_steer steer (
    .fill_active, .fill_enable, .fill_data, .tag_commit, .hit(enable && hit), .column_ix,
    .address_tag, .data_in, .write_enable, .column_enable, .column_data,
    .tag_enable, .tag_data
  );

  line_lookup lookup (
    .tag_word, .column_words, .address_tag, .column_ix, .flush_ix,
    .hit, .dirty, .victim_tag, .host_word(data_out), .flush_word
  );

  sdram_sequencer sequencer (
    .clk, .rst_n, .enable, .hit, .dirty, .line_ix, .address_tag, .victim_tag,
    .flush_word, .flush_ix, .fill_active, .fill_enable, .fill_data, .tag_commit,
    .sdrc_init_done, .sdrc_cmd_ack, .sdrc_data_out, .sdrc_cmd_en, .sdrc_cmd,
    .sdrc_addr, .sdrc_data, .sdrc_data_len
  );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
/*
  testbench clock generator
  free running clock with a 4 ns period
*/
`default_nettype none

module tb_clock (
  output logic clk
);

  timeunit 1ns;
  timeprecision 1ps;

  // first rising edge at 2 ns
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

endmodule

`default_nettype wire

/* test/sdrc_model.sv */
/*
  behavioral SDRAM controller
  word memory behind the command port with burst transfers
  and acknowledge delays of 1 to 4 cycles
*/
`default_nettype none

`include "cache_consts.svh"

module sdrc_model (
  input  wire clk,
  input  wire rst_n,
  input  wire sdrc_cmd_en,
  input  wire cache_pkg::sdrc_cmd_e sdrc_cmd,
  input  wire cache_pkg::ram_addr_t sdrc_addr,
  input  wire cache_pkg::word_t sdrc_data,
  input  wire [7:0] sdrc_data_len,
  output cache_pkg::word_t sdrc_data_out,
  output logic sdrc_init_done,
  output logic sdrc_cmd_ack
);

  timeunit 1ns;
  timeprecision 1ps;

  // only written words are stored
  cache_pkg::word_t mem [cache_pkg::ram_addr_t];
  logic [15:0] lfsr_state = 16'd62;

  // untouched words hold a mix of their full address
  function automatic cache_pkg::word_t initial_word(input cache_pkg::ram_addr_t a);
    return (32'(a) * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  function automatic cache_pkg::word_t read_word(input cache_pkg::ram_addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return initial_word(a);
  endfunction

  // galois lfsr, one step per bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 16'hb400;
    end
    return out;
  endfunction

  function automatic int ack_delay();
    logic [1:0] r;
    r[1] = lfsr_bit();
    r[0] = lfsr_bit();
    return 1 + int'(r);
  endfunction

  // entered at the edge that sees the strobe
  task automatic serve_command(input cache_pkg::sdrc_cmd_e cmd,
                               input cache_pkg::ram_addr_t addr, input int words);
    if (cmd == cache_pkg::CMD_WRITE) begin
      // word 0 rides with the strobe
      mem[addr] = sdrc_data;
      for (int k = 1; k < words; k++) begin
        @(posedge clk);
        mem[addr + cache_pkg::ram_addr_t'(k)] = sdrc_data;
      end
    end else if (cmd == cache_pkg::CMD_READ) begin
      // word 0 lands READ_WAITS+1 cycles after the strobe
      repeat (`CACHE_READ_WAITS) @(posedge clk);
      for (int k = 0; k < words; k++) begin
        if (k > 0) begin
          @(posedge clk);
        end
        sdrc_data_out <= read_word(addr + cache_pkg::ram_addr_t'(k));
      end
    end
    repeat (ack_delay()) @(posedge clk);
    sdrc_cmd_ack <= 1'b1;
    @(posedge clk);
    sdrc_cmd_ack <= 1'b0;
  endtask

  initial begin
    sdrc_data_out = '0;
    sdrc_init_done = 1'b0;
    sdrc_cmd_ack = 1'b0;
    wait (rst_n === 1'b1);
    // power-up sequence of the controller
    repeat (20) @(posedge clk);
    sdrc_init_done <= 1'b1;
    forever begin
      @(posedge clk);
      if (sdrc_cmd_en === 1'b1) begin
        serve_command(sdrc_cmd, sdrc_addr, int'(sdrc_data_len) + 1);
      end
    end
  end

endmodule

`default_nettype wire

/* test/sdram_cache_checker.sv */
/*
  SDRAM cache protocol checker
  concurrent assertions on the controller strobe and the host outputs
*/
`default_nettype none

module sdram_cache_checker (
  input  wire clk,
  input  wire rst_n,
  input  wire data_out_ready,
  input  wire cache_pkg::word_t data_out,
  input  wire sdrc_cmd_en,
  input  wire sdrc_cmd_ack
);

  timeunit 1ns;
  timeprecision 1ps;

  int failures = 0;
  // a command is out and not yet acknowledged
  logic pending;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (sdrc_cmd_en) begin
      pending <= 1'b1;
    end else if (sdrc_cmd_ack) begin
      pending <= 1'b0;
    end
  end

  strobe_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) sdrc_cmd_en |=> !sdrc_cmd_en
  ) else begin
    failures++;
    $error("command strobe high two cycles running");
  end

  strobe_after_ack: assert property (
    @(posedge clk) disable iff (!rst_n) sdrc_cmd_en |-> !pending
  ) else begin
    failures++;
    $error("command strobe before the previous acknowledge");
  end

  // strobe held low all through reset
  quiet_in_reset: assert property (
    @(posedge clk) !rst_n |=> !sdrc_cmd_en
  ) else begin
    failures++;
    $error("command strobe during reset");
  end

  // read data comes from the RAM read of the cycle before
  ready_data_settled: assert property (
    @(posedge clk) disable iff (!rst_n) data_out_ready |-> $stable(data_out)
  ) else begin
    failures++;
    $error("data_out changed in the cycle data_out_ready was raised");
  end

endmodule

`default_nettype wire

/* test/sdram_cache_tb.sv */
/*
  SDRAM cache testbench
  lfsr driven host reads and writes against a reference word array,
  refresh spacing monitor and watchdog
*/
`default_nettype none

`include "cache_consts.svh"

module sdram_cache_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RANDOM_OPS = 150;
  // refresh waits, untouched reads, write/read pairs, alternating tags
  localparam int TOTAL_OPS = 2 + 32 + 2 * RANDOM_OPS + 32;

  logic clk;
  logic rst_n;
  logic enable;
  logic [31:0] address;
  cache_pkg::word_t data_in;
  cache_pkg::byte_en_t write_enable;
  cache_pkg::word_t data_out;
  logic data_out_ready;
  logic busy;
  logic sdrc_cmd_en;
  cache_pkg::sdrc_cmd_e sdrc_cmd;
  cache_pkg::ram_addr_t sdrc_addr;
  cache_pkg::word_t sdrc_data;
  logic [7:0] sdrc_data_len;
  cache_pkg::word_t sdrc_data_out;
  logic sdrc_init_done;
  logic sdrc_cmd_ack;

  // 2 tags x 4 lines x 8 columns
  cache_pkg::word_t expected_mem [64];
  logic [15:0] lfsr_state = 16'd62;
  int cycles = 0;
  int last_refresh = 0;
  logic refresh_seen = 1'b0;

  tb_clock clock_gen (.clk);

  sdram_cache DUT (
    .clk, .rst_n, .enable, .address, .data_in, .write_enable, .data_out,
    .data_out_ready, .busy, .sdrc_cmd_en, .sdrc_cmd, .sdrc_addr, .sdrc_data,
    .sdrc_data_len, .sdrc_data_out, .sdrc_init_done, .sdrc_cmd_ack
  );

  sdrc_model controller (
    .clk, .rst_n, .sdrc_cmd_en, .sdrc_cmd, .sdrc_addr, .sdrc_data,
    .sdrc_data_len, .sdrc_data_out, .sdrc_init_done, .sdrc_cmd_ack
  );

  bind sdram_cache sdram_cache_checker protocol_check (
    .clk(clk), .rst_n(rst_n), .data_out_ready(data_out_ready), .data_out(data_out),
    .sdrc_cmd_en(sdrc_cmd_en), .sdrc_cmd_ack(sdrc_cmd_ack)
  );

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 16'hb400;
    end
    return out;
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // same address mix as the controller memory
  function automatic cache_pkg::word_t initial_word(input cache_pkg::ram_addr_t a);
    return (32'(a) * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  function automatic cache_pkg::word_t merge_bytes(input cache_pkg::word_t old_word,
      input cache_pkg::word_t new_word, input cache_pkg::byte_en_t be);
    cache_pkg::word_t w;
    w = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        w[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return w;
  endfunction

  // slot bits {tag select, line select, column}
  function automatic cache_pkg::ram_addr_t slot_ram_addr(input logic [5:0] slot);
    cache_pkg::tag_t tag;
    cache_pkg::line_ix_t line;
    tag = slot[5] ? cache_pkg::tag_t'(12'h35c) : cache_pkg::tag_t'(12'h0a5);
    case (slot[4:3])
      2'd0: line = 6'd0;
      2'd1: line = 6'd9;
      2'd2: line = 6'd34;
      default: line = 6'd63;
    endcase
    return {tag, line, slot[2:0]};
  endfunction

  // byte address with random low bits, which the cache ignores
  function automatic logic [31:0] host_address(input logic [5:0] slot);
    return (32'(slot_ram_addr(slot)) << 2) | random_bits(2);
  endfunction

  task automatic check_word(input cache_pkg::word_t actual,
      input cache_pkg::word_t expected, input logic [31:0] addr);
    if (actual !== expected) begin
      fail_run($sformatf("Error at %0t ns: read of %h returned %h, expected %h",
                         $time, addr, actual, expected));
    end
  endtask

  task automatic check_cmd(input cache_pkg::sdrc_cmd_e actual,
      input cache_pkg::sdrc_cmd_e expected);
    if (actual !== expected) begin
      fail_run($sformatf("Error at %0t ns: controller command %b, expected %b",
                         $time, actual, expected));
    end
  endtask

  task automatic check_len(input logic [7:0] actual, input logic [7:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("Error at %0t ns: burst length %0d, expected %0d",
                         $time, actual, expected));
    end
  endtask

  task automatic next_command(output cache_pkg::sdrc_cmd_e cmd);
    @(posedge clk);
    while (sdrc_cmd_en !== 1'b1) begin
      @(posedge clk);
    end
    cmd = sdrc_cmd;
  endtask

  // address first, then data and enables, then the request
  task automatic host_access(input logic [31:0] addr, input cache_pkg::byte_en_t be,
      input cache_pkg::word_t wdata, output cache_pkg::word_t rdata, output logic ready);
    int waited;
    waited = 0;
    @(posedge clk);
    address <= addr;
    @(posedge clk);
    data_in <= wdata;
    write_enable <= be;
    @(posedge clk);
    enable <= 1'b1;
    @(posedge clk);
    // values sampled here belong to the cycle just ended
    while (busy) begin
      waited++;
      if (waited > 400) begin
        fail_run("host request not answered, busy stayed high");
      end
      @(posedge clk);
    end
    rdata = data_out;
    ready = data_out_ready;
    enable <= 1'b0;
    write_enable <= '0;
  endtask

  task automatic read_check(input logic [5:0] slot);
    logic [31:0] addr;
    cache_pkg::word_t rdata;
    logic ready;
    addr = host_address(slot);
    host_access(addr, 4'b0000, '0, rdata, ready);
    if (ready !== 1'b1) begin
      fail_run("read accepted without data_out_ready");
    end
    check_word(rdata, expected_mem[slot], addr);
  endtask

  task automatic write_slot(input logic [5:0] slot, input cache_pkg::byte_en_t be,
      input cache_pkg::word_t wdata);
    cache_pkg::word_t rdata;
    logic ready;
    host_access(host_address(slot), be, wdata, rdata, ready);
    if (ready !== 1'b0) begin
      fail_run("data_out_ready raised for a write");
    end
    expected_mem[slot] = merge_bytes(expected_mem[slot], wdata, be);
  endtask

  // refresh spacing, burst length and bound assertion failures
  always @(posedge clk) begin
    cycles++;
    if (DUT.protocol_check.failures != 0) begin
      fail_run("a protocol assertion in the bound checker failed");
    end
    if (sdrc_cmd_en === 1'b1 &&
        (sdrc_cmd == cache_pkg::CMD_READ || sdrc_cmd == cache_pkg::CMD_WRITE)) begin
      check_len(sdrc_data_len, 8'd7);
    end
    if (sdrc_cmd_en === 1'b1 && sdrc_cmd == cache_pkg::CMD_REFRESH) begin
      if (refresh_seen && cycles - last_refresh < `CACHE_REFRESH_PERIOD) begin
        fail_run($sformatf("Error at %0t ns: refreshes %0d cycles apart, expected %0d or more",
                           $time, cycles - last_refresh, `CACHE_REFRESH_PERIOD));
      end
      refresh_seen = 1'b1;
      last_refresh = cycles;
    end
  end

  initial begin
    #(TOTAL_OPS * 120 * 4);
    fail_run("watchdog expired before the tests finished");
  end

  initial begin
    logic [5:0] slot;
    cache_pkg::byte_en_t be;
    cache_pkg::word_t wdata;
    cache_pkg::sdrc_cmd_e cmd;
    rst_n = 1'b0;
    enable = 1'b0;
    address = '0;
    data_in = '0;
    write_enable = '0;
    for (int s = 0; s < 64; s++) begin
      expected_mem[s] = initial_word(slot_ram_addr(6'(s)));
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // host idle so only refreshes go out
    wait (sdrc_init_done === 1'b1);
    next_command(cmd);
    check_cmd(cmd, cache_pkg::CMD_REFRESH);
    next_command(cmd);
    check_cmd(cmd, cache_pkg::CMD_REFRESH);

    // untouched words fill each line once and then hit
    for (int s = 0; s < 32; s++) begin
      read_check(6'(s));
    end

    // random writes each read back
    for (int i = 0; i < RANDOM_OPS; i++) begin
      slot = 6'(random_bits(6));
      be = 4'(random_bits(4));
      wdata = random_bits(32);
      if (be != '0) begin
        write_slot(slot, be, wdata);
      end
      read_check(slot);
    end

    // both tags share one line and every write evicts a dirty line
    for (int r = 0; r < 8; r++) begin
      write_slot({1'b0, 2'd2, 3'(r)}, 4'b1111, random_bits(32));
      write_slot({1'b1, 2'd2, 3'(r)}, 4'b1111, random_bits(32));
    end
    for (int r = 0; r < 8; r++) begin
      read_check({1'b0, 2'd2, 3'(r)});
      read_check({1'b1, 2'd2, 3'(r)});
    end

    if (DUT.protocol_check.failures == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+common
common/cache_pkg.sv
cache/line_ram.sv
cache/line_fill_steer.sv
cache/line_lookup.sv
cache/sdram_sequencer.sv
verilog/sdram_cache.sv
test/tb_clock.sv
test/sdrc_model.sv
test/sdram_cache_checker.sv
test/sdram_cache_tb.sv
